/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_issue
FILELIST  = tb.f
BUILD     = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* isa_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction-set types shared by all pipeline stages
// register numbers, data words and the decoded instruction record
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package isa_pkg;

    // architectural register number, r0 .. r31
    typedef logic [4:0] reg_addr_t;

    // data word, also used for program counters
    typedef logic [31:0] word_t;

    // one decoded instruction as it leaves decode
    typedef struct packed {
        // address of the instruction
        word_t     pc;
        // first and second source registers
        reg_addr_t srca;
        reg_addr_t srcb;
        // destination register, only meaningful with regwrite
        reg_addr_t dest;
        logic      regwrite;
        // load or store
        logic      mem_access;
        // branch, jump or jump-register, all with a delay slot
        logic      branch;
        // multiply or divide, one unit shared by both slots
        logic      muldiv;
    } decode_t;

endpackage

`default_nettype wire

/* issue_latch.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue register
// joins register-file operands to the chosen instructions and holds them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module issue_latch
    import isa_pkg::*, issue_pkg::*;
(
    input  wire                clk,
    input  wire                reset,
    input  wire decode_t       head_a,
    input  wire decode_t       head_b,
    input  wire pair_en_t      pair_en,
    // slot a srca, slot a srcb, slot b srca, slot b srcb
    input  wire word_t [3:0]   reg_data,
    input  wire                stall,
    input  wire                flush_exec,
    output issue_pair_t        out
);

    issue_pair_t next_out;

    // a slot that does not issue stays all zero
    function automatic issue_t build_slot(
        input logic    sel,
        input decode_t d,
        input word_t   opa,
        input word_t   opb
    );
        issue_t r;
        r = '0;
        if (sel)
        begin
            r.valid      = 1'b1;
            r.pc         = d.pc;
            r.dest       = d.dest;
            r.regwrite   = d.regwrite;
            r.mem_access = d.mem_access;
            r.branch     = d.branch;
            r.muldiv     = d.muldiv;
            r.opa        = opa;
            r.opb        = opb;
        end
        return r;
    endfunction

    assign next_out[1] = build_slot(pair_en[1], head_a, reg_data[3], reg_data[2]);
    assign next_out[0] = build_slot(pair_en[0], head_b, reg_data[1], reg_data[0]);

    // flush wins over stall, stall holds the pair in place
    always_ff @(posedge clk)
    begin
        if (!reset || flush_exec)
            out <= '0;
        else if (!stall)
            out <= next_out;
    end

    // execute never sees a lone younger instruction
    assert property (@(posedge clk) disable iff (!reset)
        out[0].valid |-> out[1].valid);

endmodule

`default_nettype wire

/* issue_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue-stage types
// issued instruction record, issue pair and pair-enable vector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package issue_pkg;

    import isa_pkg::*;

    // one instruction as handed to execute, operands already read
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dest;
        logic      regwrite;
        logic      mem_access;
        logic      branch;
        logic      muldiv;
        // operand words for srca and srcb
        word_t     opa;
        word_t     opb;
    } issue_t;

    // index 1 is slot a (older), index 0 is slot b
    typedef issue_t [1:0] issue_pair_t;

    // bit 1 -> slot a issues, bit 0 -> slot b issues
    // legal values 00, 10, 11
    typedef logic [1:0] pair_en_t;

    // queue depth unless the top level overrides it
    localparam int QUEUE_DEPTH_DEFAULT = 8;

endpackage

`default_nettype wire

/* issue_queue.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue queue
// circular buffer of decoded instructions, two in and two out per cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module issue_queue
    import isa_pkg::*, issue_pkg::*;
#(
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT
)
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire decode_t [1:0]  in,
    input  wire [1:0]           hit,
    input  wire pair_en_t       pair_en,
    input  wire                 stall,
    input  wire                 flush_queue,
    output decode_t             head_a,
    output decode_t             head_b,
    output logic                head_a_valid,
    output logic                head_b_valid,
    output logic                queue_full
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    // slot index into the entry array
    typedef logic [IDX_W-1:0] idx_t;
    // pointer with one extra wrap bit, also wide enough for counts
    typedef logic [IDX_W:0] ptr_t;

    decode_t [QUEUE_DEPTH-1:0] entry;
    logic [QUEUE_DEPTH-1:0]    entry_valid;

    ptr_t head;
    ptr_t tail;

    idx_t head_a_idx;
    idx_t head_b_idx;
    idx_t tail_idx;
    idx_t wr_b_idx;

    ptr_t push_cnt;
    ptr_t pop_cnt;
    ptr_t free_cnt;

    assign head_a_idx = head[IDX_W-1:0];
    assign head_b_idx = head_a_idx + idx_t'(1);
    assign tail_idx   = tail[IDX_W-1:0];
    // in[0] lands behind in[1] only when both are strobed
    assign wr_b_idx   = hit[1] ? tail_idx + idx_t'(1) : tail_idx;

    assign push_cnt = ptr_t'(hit[1]) + ptr_t'(hit[0]);
    assign pop_cnt  = ptr_t'(pair_en[1]) + ptr_t'(pair_en[0]);

    // occupancy from the pointers, the wrap bit tells full from empty
    assign free_cnt   = ptr_t'(QUEUE_DEPTH) - (tail - head);
    // judged before this cycle's pop, whole pair rejected
    assign queue_full = push_cnt > free_cnt;

    // two oldest entries go to pair check and the operand read
    assign head_a       = entry[head_a_idx];
    assign head_b       = entry[head_b_idx];
    assign head_a_valid = entry_valid[head_a_idx];
    assign head_b_valid = entry_valid[head_b_idx];

    // pointers and valid bits
    always_ff @(posedge clk)
    begin
        if (!reset || flush_queue)
        begin
            head        <= '0;
            tail        <= '0;
            entry_valid <= '0;
        end
        else
        begin
            // pop the entries that pair check let go
            if (!stall)
            begin
                if (pair_en[1])
                    entry_valid[head_a_idx] <= 1'b0;
                if (pair_en[0])
                    entry_valid[head_b_idx] <= 1'b0;
                head <= head + pop_cnt;
            end
            // push into free slots, never the ones popped above
            if (!queue_full)
            begin
                if (hit[1])
                    entry_valid[tail_idx] <= 1'b1;
                if (hit[0])
                    entry_valid[wr_b_idx] <= 1'b1;
                tail <= tail + push_cnt;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk)
    begin
        if (!flush_queue && !queue_full)
        begin
            if (hit[1])
                entry[tail_idx] <= in[1];
            if (hit[0])
                entry[wr_b_idx] <= in[0];
        end
    end

    // pair check must only release entries that hold an instruction
    assert property (@(posedge clk) disable iff (!reset)
        (!stall && !flush_queue && pair_en[1]) |-> entry_valid[head_a_idx]);
    assert property (@(posedge clk) disable iff (!reset)
        (!stall && !flush_queue && pair_en[0]) |-> entry_valid[head_b_idx]);

    // slot b never leaves ahead of slot a
    assert property (@(posedge clk) disable iff (!reset) pair_en != 2'b01);

endmodule

`default_nettype wire

/* issue_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage top
// issue queue, pair check and issue register of the dual-issue core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module issue_stage
    import isa_pkg::*, issue_pkg::*;
#(
    // power of two, at least 4
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT
)
(
    input  wire                  clk,
    input  wire                  reset,
    // index 1 is older, filled first
    input  wire decode_t [1:0]   in,
    input  wire [1:0]            hit,
    input  wire                  stall,
    input  wire                  flush_queue,
    input  wire                  flush_exec,
    input  wire word_t [3:0]     reg_data,
    output issue_pair_t          out,
    output logic                 queue_full,
    output reg_addr_t [3:0]      reg_addr
);

    decode_t  head_a;
    decode_t  head_b;
    logic     head_a_valid;
    logic     head_b_valid;
    pair_en_t pair_en;

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .reset        (reset),
        .in           (in),
        .hit          (hit),
        .pair_en      (pair_en),
        .stall        (stall),
        .flush_queue  (flush_queue),
        .head_a       (head_a),
        .head_b       (head_b),
        .head_a_valid (head_a_valid),
        .head_b_valid (head_b_valid),
        .queue_full   (queue_full)
    );

    pair_check u_pair (
        .head_a       (head_a),
        .head_b       (head_b),
        .head_a_valid (head_a_valid),
        .head_b_valid (head_b_valid),
        .pair_en      (pair_en)
    );

    // register file read straight off the queue head
    assign reg_addr = {head_a.srca, head_a.srcb, head_b.srca, head_b.srcb};

    issue_latch u_latch (
        .clk        (clk),
        .reset      (reset),
        .head_a     (head_a),
        .head_b     (head_b),
        .pair_en    (pair_en),
        .reg_data   (reg_data),
        .stall      (stall),
        .flush_exec (flush_exec),
        .out        (out)
    );

endmodule

`default_nettype wire

/* pair_check.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-issue pair check
// decides whether the head issues and whether the next one joins it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module pair_check
    import isa_pkg::*, issue_pkg::*;
(
    input  wire decode_t  head_a,
    input  wire decode_t  head_b,
    input  wire           head_a_valid,
    input  wire           head_b_valid,
    output pair_en_t      pair_en
);

    logic wait_delay_slot;
    logic issue_a;
    logic raw_hazard;
    logic mem_conflict;
    logic muldiv_conflict;
    logic branch_in_b;
    logic issue_b;

    // a branch holds until its delay slot sits behind it
    assign wait_delay_slot = head_a.branch && !head_b_valid;
    assign issue_a         = head_a_valid && !wait_delay_slot;

    // slot b reads what slot a writes
    // r0 counts as a hazard as well
    assign raw_hazard = head_a.regwrite &&
                        ((head_a.dest == head_b.srca) || (head_a.dest == head_b.srcb));

    // single memory port
    assign mem_conflict = head_a.mem_access && head_b.mem_access;

    // single multiply/divide unit
    assign muldiv_conflict = head_a.muldiv && head_b.muldiv;

    // branch in b has its delay slot still in the queue, let it lead next cycle
    assign branch_in_b = head_b.branch;

    assign issue_b = issue_a && head_b_valid &&
                     !(branch_in_b || raw_hazard || mem_conflict || muldiv_conflict);

    assign pair_en = {issue_a, issue_b};

endmodule

`default_nettype wire

/* tb.f */
isa_pkg.sv
issue_pkg.sv
issue_queue.sv
pair_check.sv
issue_latch.sv
issue_stage.sv
tb_clock.sv
tb_issue.sv

/* tb_clock.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset generator
// 100 ns clock, active-low reset held for 8 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial
    begin
        reset = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_issue.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue stage testbench
// register-file model, queue model, directed and random stimulus, checker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_issue
    import isa_pkg::*, issue_pkg::*;
();

    localparam int DEPTH   = 8;
    localparam int TIMEOUT = 100;

    logic            clk;
    logic            reset;
    decode_t [1:0]   in_pair;
    logic [1:0]      hit;
    logic            stall;
    logic            flush_queue;
    logic            flush_exec;
    word_t [3:0]     reg_data;
    issue_pair_t     out;
    logic            queue_full;
    reg_addr_t [3:0] reg_addr;

    // model queue, index 0 is the oldest entry
    decode_t     mq[$];
    issue_pair_t exp_out;

    tb_clock u_clock (.clk(clk), .reset(reset));

    issue_stage #(.QUEUE_DEPTH(DEPTH)) UUT (
        .clk(clk), .reset(reset), .in(in_pair), .hit(hit), .stall(stall),
        .flush_queue(flush_queue), .flush_exec(flush_exec), .reg_data(reg_data),
        .out(out), .queue_full(queue_full), .reg_addr(reg_addr)
    );

    // register file contents, address in the top byte
    function automatic word_t rf_word(input reg_addr_t a);
        return {3'b000, a, 24'hC35A96};
    endfunction

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            reg_data[i] = rf_word(reg_addr[i]);
    end

    // flags are {regwrite, mem_access, branch, muldiv}
    function automatic decode_t make_instr(input word_t pc, input reg_addr_t sa,
                                           input reg_addr_t sb, input reg_addr_t d,
                                           input logic [3:0] flags);
        return '{pc, sa, sb, d, flags[3], flags[2], flags[1], flags[0]};
    endfunction

    // small register range so hazards show up often
    function automatic decode_t rand_instr();
        return make_instr($urandom, 5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                          5'($urandom_range(7, 0)),
                          {1'($urandom_range(1, 0)), $urandom_range(3, 0) == 0,
                           $urandom_range(7, 0) == 0, $urandom_range(5, 0) == 0});
    endfunction

    // pairing rules applied to the n oldest model entries
    function automatic pair_en_t ref_pair(input decode_t a, input decode_t b, input int n);
        logic ia;
        logic ib;
        ia = (n >= 1) && !(a.branch && n < 2);
        ib = ia && (n >= 2) && !b.branch && !(a.mem_access && b.mem_access) &&
             !(a.muldiv && b.muldiv) &&
             !(a.regwrite && (a.dest == b.srca || a.dest == b.srcb));
        return {ia, ib};
    endfunction

    // expected record of one slot, empty slots are all zero
    function automatic issue_t ref_issue(input logic sel, input decode_t d);
        issue_t r;
        r = '0;
        if (sel)
            r = '{1'b1, d.pc, d.dest, d.regwrite, d.mem_access, d.branch, d.muldiv,
                  rf_word(d.srca), rf_word(d.srcb)};
        return r;
    endfunction

    function automatic logic model_full(input logic [1:0] h, input int used);
        return (int'(h[1]) + int'(h[0])) > (DEPTH - used);
    endfunction

    task automatic check(input string name, input logic [255:0] got,
                         input logic [255:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // one strobe of the enqueue pair
    task automatic push(input decode_t a, input decode_t b, input logic [1:0] h);
        in_pair = {a, b};
        hit     = h;
        step();
        hit     = 2'b00;
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (mq.size() != 0 || out[1].valid)
        begin
            step();
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail("issue queue did not drain");
        end
    endtask

    // queue model and issue register model, advanced on every edge
    always @(posedge clk)
    begin : model
        decode_t  ha;
        decode_t  hb;
        pair_en_t pen;
        logic     full;
        int       n;
        n    = mq.size();
        ha   = (n > 0) ? mq[0] : '0;
        hb   = (n > 1) ? mq[1] : '0;
        pen  = ref_pair(ha, hb, n);
        full = model_full(hit, n);
        if (!reset)
        begin
            mq.delete();
            exp_out = '0;
        end
        else
        begin
            // flush of the issue register wins over stall
            if (flush_exec)
                exp_out = '0;
            else if (!stall)
                exp_out = {ref_issue(pen[1], ha), ref_issue(pen[0], hb)};
            if (flush_queue)
                mq.delete();
            else
            begin
                if (!stall && pen[1])
                    mq.delete(0);
                if (!stall && pen[0])
                    mq.delete(0);
                if (!full && hit[1])
                    mq.push_back(in_pair[1]);
                if (!full && hit[0])
                    mq.push_back(in_pair[0]);
            end
        end
    end

    // mid-cycle compare, everything settled by then
    always @(negedge clk)
    begin
        check("out", out, exp_out);
        check("queue_full", queue_full, model_full(hit, mq.size()));
        // register file read addresses follow the two oldest entries
        if (mq.size() > 0)
        begin
            check("reg_addr[3]", reg_addr[3], mq[0].srca);
            check("reg_addr[2]", reg_addr[2], mq[0].srcb);
        end
        if (mq.size() > 1)
        begin
            check("reg_addr[1]", reg_addr[1], mq[1].srca);
            check("reg_addr[0]", reg_addr[0], mq[1].srcb);
        end
    end

    initial
    begin : stimulus
        int cnt;
        void'($urandom(51831));
        in_pair     = '0;
        hit         = 2'b00;
        stall       = 1'b0;
        flush_queue = 1'b0;
        flush_exec  = 1'b0;
        cnt = 0;
        while (!reset)
        begin
            step();
            cnt++;
            if (cnt > 20)
                timeout_fail("reset was never released");
        end
        step();
        check("out.valid", {out[1].valid, out[0].valid}, 2'b00);

        // independent pair leaves together, two edges after the strobe
        // the empty queue must take the whole pair
        in_pair = {make_instr(32'h100, 5'd1, 5'd2, 5'd3, 4'b1000),
                   make_instr(32'h104, 5'd4, 5'd5, 5'd6, 4'b1000)};
        hit     = 2'b11;
        #10;
        check("queue_full", queue_full, 1'b0);
        step();
        hit     = 2'b00;
        cnt = 1;
        while (!out[1].valid)
        begin
            step();
            cnt++;
            if (cnt > TIMEOUT)
                timeout_fail("independent pair never issued");
        end
        check("latency", cnt, 2);
        check("out[0].valid", out[0].valid, 1'b1);
        wait_idle();

        // split cases, read after write, memory, muldiv, branch in slot b
        push(make_instr(32'h200, 5'd1, 5'd2, 5'd7, 4'b1000),
             make_instr(32'h204, 5'd7, 5'd3, 5'd8, 4'b1000), 2'b11);
        wait_idle();
        push(make_instr(32'h300, 5'd1, 5'd2, 5'd9, 4'b1100),
             make_instr(32'h304, 5'd3, 5'd4, 5'd0, 4'b0100), 2'b11);
        wait_idle();
        push(make_instr(32'h400, 5'd1, 5'd2, 5'd0, 4'b0001),
             make_instr(32'h404, 5'd3, 5'd4, 5'd0, 4'b0001), 2'b11);
        wait_idle();
        push(make_instr(32'h500, 5'd1, 5'd2, 5'd3, 4'b1000),
             make_instr(32'h504, 5'd4, 5'd5, 5'd0, 4'b0010), 2'b11);
        push(make_instr(32'h508, 5'd6, 5'd7, 5'd8, 4'b1000), '0, 2'b10);
        wait_idle();

        // lone branch waits for its delay slot
        push(make_instr(32'h600, 5'd1, 5'd2, 5'd0, 4'b0010), '0, 2'b10);
        repeat (4) step();
        check("out[1].valid", out[1].valid, 1'b0);
        push(make_instr(32'h604, 5'd3, 5'd4, 5'd5, 4'b1000), '0, 2'b10);
        wait_idle();

        // fill under stall, fifth pair is dropped
        stall = 1'b1;
        for (int i = 0; i < 5; i++)
        begin
            in_pair = {make_instr(32'h700 + 8 * i, 5'd1, 5'd2, 5'd3, 4'b0000),
                       make_instr(32'h704 + 8 * i, 5'd4, 5'd5, 5'd6, 4'b0000)};
            hit = 2'b11;
            #10;
            check("queue_full", queue_full, i == 4);
            step();
        end
        hit   = 2'b00;
        stall = 1'b0;
        wait_idle();

        // random traffic against the model
        repeat (400)
        begin
            in_pair     = {rand_instr(), rand_instr()};
            hit         = 2'($urandom_range(3, 0));
            stall       = $urandom_range(3, 0) == 0;
            flush_queue = $urandom_range(19, 0) == 0;
            flush_exec  = $urandom_range(19, 0) == 0;
            step();
        end
        // a lone branch may be left at the head, clear it out
        hit         = 2'b00;
        stall       = 1'b0;
        flush_exec  = 1'b0;
        flush_queue = 1'b1;
        step();
        flush_queue = 1'b0;
        wait_idle();
        repeat (3) step();
        check("out.valid", {out[1].valid, out[0].valid}, 2'b00);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
